// ==== hw/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// line geometry
`define DC_LINE_BITS 256
`define DC_WORDS 8

// address split, tag + index + offset = 32
`define DC_TAG_BITS 22
`define DC_INDEX_BITS 5
`define DC_OFFSET_BITS 5

// number of lines held, one per index value
`define DC_LINES 32

`endif

// ==== hw/dcache_addr_pkg.sv ====
`include "dcache_consts.svh"

package dcache_addr_pkg;

  // processor address split into its cache fields
  typedef struct packed {
    logic [`DC_TAG_BITS-1:0]    tag;
    logic [`DC_INDEX_BITS-1:0]  index;
    logic [`DC_OFFSET_BITS-1:0] offset;
  } dc_addr_fields_s;

  // one address word, seen as raw bits or as fields
  typedef union packed {
    logic [31:0]     raw;
    dc_addr_fields_s f;
  } dc_addr_u;

  // one cache line, seen as raw bits or as words
  // word 0 sits in the least significant bits
  typedef union packed {
    logic [`DC_LINE_BITS-1:0]     raw;
    logic [`DC_WORDS-1:0][31:0]   words;
  } dc_line_u;

endpackage

// ==== hw/dcache_ctrl_pkg.sv ====
`include "dcache_consts.svh"

package dcache_ctrl_pkg;

  // miss handling sequence
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    MISS       = 3'd1,
    WRITEBACK  = 3'd2,
    READMISS   = 3'd3,
    READMISSOK = 3'd4
  } dc_state_e;

  // one tag store entry, 24 bits wide
  typedef struct packed {
    logic                    valid;
    logic                    dirty;
    logic [`DC_TAG_BITS-1:0] tag;
  } dc_tag_entry_s;

endpackage

// ==== hw/dcache_tag_sram.sv ====
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_tag_sram (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [`DC_INDEX_BITS-1:0]      index_i,
  input  dcache_ctrl_pkg::dc_tag_entry_s entry_i,
  input  logic                           write_i,
  output dcache_ctrl_pkg::dc_tag_entry_s entry_o
);

  import dcache_ctrl_pkg::*;

  dc_tag_entry_s mem [`DC_LINES];

  // only the valid bits are cleared, tags and dirty bits are don't care
  // until a line is valid again
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      for (int i = 0; i < `DC_LINES; i++) begin
        mem[i].valid <= 1'b0;
      end
    end else if (write_i) begin
      mem[index_i] <= entry_i;
    end
  end

  // read is combinational so the hit is known in the request cycle
  assign entry_o = mem[index_i];

endmodule

// ==== hw/dcache_data_sram.sv ====
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_data_sram (
  input  logic                        clk_i,
  input  logic [`DC_INDEX_BITS-1:0]   index_i,
  input  dcache_addr_pkg::dc_line_u   line_i,
  input  logic                        write_i,
  output dcache_addr_pkg::dc_line_u   line_o
);

  import dcache_addr_pkg::*;

  dc_line_u mem [`DC_LINES];

  // whole line written at once, both for refill and for write hits
  always_ff @(posedge clk_i) begin
    if (write_i) begin
      mem[index_i] <= line_i;
    end
  end

  // read data also feeds the writeback path
  assign line_o = mem[index_i];

endmodule

// ==== hw/dcache_controller.sv ====
`timescale 1ns/1ns

module dcache_controller (
  input  logic clk_i,
  input  logic rst_i,
  input  logic req_i,
  input  logic hit_i,
  input  logic dirty_i,
  input  logic mem_ack_i,
  output logic stall_o,
  output logic mem_enable_o,
  output logic mem_write_o,
  output logic write_back_o,
  output logic refill_o
);

  import dcache_ctrl_pkg::*;

  dc_state_e state;
  dc_state_e state_next;
  logic      mem_enable;
  logic      mem_write;

  // next state
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        // wait for a request that misses
        if (req_i && !hit_i) begin
          state_next = MISS;
        end
      end
      MISS: begin
        // dirty victim goes out before the refill
        if (dirty_i) begin
          state_next = WRITEBACK;
        end else begin
          state_next = READMISS;
        end
      end
      WRITEBACK: begin
        if (mem_ack_i) begin
          state_next = READMISS;
        end
      end
      READMISS: begin
        if (mem_ack_i) begin
          state_next = READMISSOK;
        end
      end
      READMISSOK: begin
        state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // memory strobes are registered so they stay steady for a whole transfer
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      mem_enable <= 1'b0;
      mem_write  <= 1'b0;
    end else begin
      case (state)
        MISS: begin
          mem_enable <= 1'b1;
          mem_write  <= dirty_i;
        end
        WRITEBACK: begin
          // enable stays high, the read of the new line follows directly
          if (mem_ack_i) begin
            mem_write <= 1'b0;
          end
        end
        READMISS: begin
          if (mem_ack_i) begin
            mem_enable <= 1'b0;
            mem_write  <= 1'b0;
          end
        end
        default: begin
          mem_enable <= 1'b0;
          mem_write  <= 1'b0;
        end
      endcase
    end
  end

  assign mem_enable_o = mem_enable;
  assign mem_write_o  = mem_write;

  // victim tag drives the memory address only while writing back
  assign write_back_o = (state == WRITEBACK);

  // refill lands on the ack edge, while mem_data_i is still valid
  assign refill_o = (state == READMISS) && mem_ack_i;

  // hold the core until the sequence is back in IDLE and the access hits
  assign stall_o = req_i && (!hit_i || (state != IDLE));

endmodule

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_top (
  input  logic                      clk_i,
  input  logic                      rst_i,

  // line memory side
  input  logic [`DC_LINE_BITS-1:0]  mem_data_i,
  input  logic                      mem_ack_i,
  output logic [`DC_LINE_BITS-1:0]  mem_data_o,
  output logic [31:0]               mem_addr_o,
  output logic                      mem_enable_o,
  output logic                      mem_write_o,

  // processor side
  input  logic [31:0]               p1_data_i,
  input  logic [31:0]               p1_addr_i,
  input  logic                      p1_MemRead_i,
  input  logic                      p1_MemWrite_i,
  output logic [31:0]               p1_data_o,
  output logic                      p1_stall_o
);

  import dcache_addr_pkg::*;
  import dcache_ctrl_pkg::*;

  dc_addr_u      p1_addr;
  dc_addr_u      mem_addr;
  dc_tag_entry_s tag_rd;
  dc_tag_entry_s tag_wr;
  dc_line_u      line_rd;
  dc_line_u      line_wr;
  dc_line_u      line_merged;

  logic [$clog2(`DC_WORDS)-1:0] word_sel;
  logic                         p1_req;
  logic                         hit;
  logic                         victim_dirty;
  logic                         write_hit;
  logic                         sram_write;
  logic                         write_back;
  logic                         refill;

  assign p1_addr.raw = p1_addr_i;
  assign p1_req      = p1_MemRead_i | p1_MemWrite_i;

  // word within the line, byte bits of the offset are ignored
  assign word_sel = p1_addr.f.offset[`DC_OFFSET_BITS-1:2];

  // tag compare
  assign hit = tag_rd.valid && (tag_rd.tag == p1_addr.f.tag);

  // an invalid victim is never written back
  assign victim_dirty = tag_rd.valid && tag_rd.dirty;

  // read data straight from the line store
  assign p1_data_o = line_rd.words[word_sel];

  // store word merged into the current line
  always_comb begin
    line_merged                 = line_rd;
    line_merged.words[word_sel] = p1_data_i;
  end

  // write hit only once the controller has let the access through
  assign write_hit = hit && p1_MemWrite_i && !p1_stall_o;

  // refill brings a clean line, a write hit marks it dirty
  assign line_wr     = refill ? mem_data_i : line_merged;
  assign tag_wr      = '{valid: 1'b1, dirty: !refill, tag: p1_addr.f.tag};
  assign sram_write  = refill || write_hit;

  // line address, victim tag during writeback, request tag otherwise
  always_comb begin
    mem_addr.f.tag    = write_back ? tag_rd.tag : p1_addr.f.tag;
    mem_addr.f.index  = p1_addr.f.index;
    mem_addr.f.offset = '0;
  end

  assign mem_addr_o = mem_addr.raw;
  assign mem_data_o = line_rd.raw;

  dcache_controller u_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (p1_req),
    .hit_i        (hit),
    .dirty_i      (victim_dirty),
    .mem_ack_i    (mem_ack_i),
    .stall_o      (p1_stall_o),
    .mem_enable_o (mem_enable_o),
    .mem_write_o  (mem_write_o),
    .write_back_o (write_back),
    .refill_o     (refill)
  );

  dcache_tag_sram u_tag_sram (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .index_i (p1_addr.f.index),
    .entry_i (tag_wr),
    .write_i (sram_write),
    .entry_o (tag_rd)
  );

  dcache_data_sram u_data_sram (
    .clk_i   (clk_i),
    .index_i (p1_addr.f.index),
    .line_i  (line_wr),
    .write_i (sram_write),
    .line_o  (line_rd)
  );

endmodule

// ==== tb/data_memory_model.sv ====
`timescale 1ns/1ns
`include "dcache_consts.svh"

module data_memory_model #(
  parameter int LATENCY = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      enable_i,
  input  logic                      write_i,
  input  logic [31:0]               addr_i,
  input  dcache_addr_pkg::dc_line_u data_i,
  output logic                      ack_o,
  output dcache_addr_pkg::dc_line_u data_o
);

  import dcache_addr_pkg::*;

  // lines that were written back, keyed by line address
  dc_line_u                 lines [logic [31:0]];
  logic [31:0]              wb_addr_q [$];
  logic [`DC_LINE_BITS-1:0] wb_line_q [$];
  int                       count;

  // untouched words hold their own address xor a fixed pattern
  function automatic dc_line_u line_read(input logic [31:0] addr);
    dc_line_u l;
    if (lines.exists(addr)) begin
      l = lines[addr];
    end else begin
      for (int i = 0; i < `DC_WORDS; i++) begin
        l.words[i] = (addr + 32'(4 * i)) ^ 32'hC0DE0000;
      end
    end
    return l;
  endfunction

  // ack comes LATENCY cycles after the enable is first seen
  always @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      ack_o  <= 1'b0;
      data_o <= '0;
      count  <= 0;
    end else if (ack_o) begin
      ack_o <= 1'b0;
    end else if (enable_i) begin
      if (count == LATENCY - 1) begin
        count <= 0;
        ack_o <= 1'b1;
        if (write_i) begin
          lines[addr_i] = data_i;
          wb_addr_q.push_back(addr_i);
          wb_line_q.push_back(data_i.raw);
        end else begin
          data_o <= line_read(addr_i);
        end
      end else begin
        count <= count + 1;
      end
    end
  end

endmodule

// ==== tb/dcache_sva.sv ====
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_sva (
  input logic                      clk_i,
  input logic                      rst_i,
  input dcache_ctrl_pkg::dc_state_e state_i,
  input logic                      mem_enable_i,
  input logic                      mem_write_i,
  input logic                      mem_ack_i,
  input logic [31:0]               mem_addr_i,
  input logic [`DC_LINE_BITS-1:0]  mem_data_i,
  input logic                      p1_stall_i
);

  import dcache_ctrl_pkg::*;

  // a writeback is always part of an enabled transfer
  write_needs_enable: assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_write_i |-> mem_enable_i)
    else $error("mem_write_o high without mem_enable_o");

  // memory sees a steady request until it acks
  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
    (mem_enable_i && !mem_ack_i) |=> $stable(mem_addr_i))
    else $error("mem_addr_o changed during a transfer");

  data_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
    (mem_enable_i && !mem_ack_i) |=> $stable(mem_data_i))
    else $error("mem_data_o changed during a transfer");

  idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_i)
    (state_i == IDLE) |-> (!mem_enable_i && !mem_write_i))
    else $error("memory strobes high in IDLE");

  // core waits while a memory transfer is in flight
  stall_while_busy: assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_enable_i |-> p1_stall_i)
    else $error("p1_stall_o low during a memory transfer");

endmodule

// address and data live in the top level, the state in the controller
bind dcache_top dcache_sva sva0 (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .state_i      (u_ctrl.state),
  .mem_enable_i (mem_enable_o),
  .mem_write_i  (mem_write_o),
  .mem_ack_i    (mem_ack_i),
  .mem_addr_i   (mem_addr_o),
  .mem_data_i   (mem_data_o),
  .p1_stall_i   (p1_stall_o)
);

// ==== tb/dcache_tb.sv ====
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_tb;

  import dcache_addr_pkg::*;

  localparam int LATENCY  = 4;
  localparam int N_RANDOM = 200;

  typedef struct packed {
    logic [2:0]               test;
    logic                     wr;
    logic [31:0]              addr;
    logic [31:0]              data;        // store data or expected read data
    logic [1:0]               stall;       // 0 none, 1 stalled, 2 don't care
    logic                     wb;          // one writeback expected
    logic [31:0]              victim;
    logic [`DC_LINE_BITS-1:0] victim_line;
  } entry_s;

  logic                     clk_i;
  logic                     rst_i;
  logic [`DC_LINE_BITS-1:0] mem_data_rd;
  logic [`DC_LINE_BITS-1:0] mem_data_wr;
  logic                     mem_ack;
  logic [31:0]              mem_addr;
  logic                     mem_enable;
  logic                     mem_write;
  logic [31:0]              p1_data_wr;
  logic [31:0]              p1_data_rd;
  logic [31:0]              p1_addr;
  logic                     p1_read;
  logic                     p1_write;
  logic                     p1_stall;

  entry_s      table_q [$];
  logic [31:0] shadow [logic [31:0]];
  logic [31:0] seed;
  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;
  bit          table_done;

  dcache_top dut0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mem_data_i    (mem_data_rd),
    .mem_ack_i     (mem_ack),
    .mem_data_o    (mem_data_wr),
    .mem_addr_o    (mem_addr),
    .mem_enable_o  (mem_enable),
    .mem_write_o   (mem_write),
    .p1_data_i     (p1_data_wr),
    .p1_addr_i     (p1_addr),
    .p1_MemRead_i  (p1_read),
    .p1_MemWrite_i (p1_write),
    .p1_data_o     (p1_data_rd),
    .p1_stall_o    (p1_stall)
  );

  data_memory_model #(.LATENCY(LATENCY)) mem0 (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .enable_i (mem_enable),
    .write_i  (mem_write),
    .addr_i   (mem_addr),
    .data_i   (mem_data_wr),
    .ack_o    (mem_ack),
    .data_o   (mem_data_rd)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] make_addr(input logic [21:0] tag, input logic [4:0] index,
                                            input logic [2:0] word);
    dc_addr_u a;
    a.f.tag    = tag;
    a.f.index  = index;
    a.f.offset = {word, 2'b00};
    return a.raw;
  endfunction

  // processor view of memory, unwritten words follow the fill rule
  function automatic logic [31:0] shadow_read(input logic [31:0] addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return addr ^ 32'hC0DE0000;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1:       return "reset state";
      2:       return "read miss then hit";
      3:       return "write then read line";
      4:       return "dirty victim writeback";
      default: return "random accesses";
    endcase
  endfunction

  task automatic add_access(input int test, input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [1:0] stall,
                            input logic wb, input logic [31:0] victim);
    entry_s   e;
    dc_line_u vl;
    // victim line as memory must see it when written back
    for (int i = 0; i < `DC_WORDS; i++) begin
      vl.words[i] = shadow_read(victim + 32'(4 * i));
    end
    e.test        = 3'(test);
    e.wr          = wr;
    e.addr        = addr;
    e.stall       = stall;
    e.wb          = wb;
    e.victim      = victim;
    e.victim_line = vl.raw;
    if (wr) begin
      e.data       = wdata;
      shadow[addr] = wdata;
    end else begin
      e.data = shadow_read(addr);
    end
    table_q.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] a;
    logic [2:0]  w;
    a = make_addr(22'h11, 5'd1, 3'd1);
    add_access(2, 1'b0, a, 32'h0, 2'd1, 1'b0, 32'h0);
    add_access(2, 1'b0, a, 32'h0, 2'd0, 1'b0, 32'h0);
    a = make_addr(22'h22, 5'd2, 3'd3);
    add_access(3, 1'b1, a, 32'h1234_5678, 2'd1, 1'b0, 32'h0);
    add_access(3, 1'b0, a, 32'h0, 2'd0, 1'b0, 32'h0);
    for (int i = 0; i < `DC_WORDS; i++) begin
      add_access(3, 1'b0, make_addr(22'h22, 5'd2, 3'(i)), 32'h0, 2'd0, 1'b0, 32'h0);
    end
    // conflicting tag at index 3 pushes the dirty line out
    a = make_addr(22'h33, 5'd3, 3'd5);
    add_access(4, 1'b1, a, 32'hCAFE_F00D, 2'd1, 1'b0, 32'h0);
    add_access(4, 1'b0, make_addr(22'h44, 5'd3, 3'd0), 32'h0, 2'd1, 1'b1,
               make_addr(22'h33, 5'd3, 3'd0));
    add_access(4, 1'b0, a, 32'h0, 2'd1, 1'b0, 32'h0);
    for (int i = 0; i < N_RANDOM; i++) begin
      seed = lcg_next(seed);
      w    = seed[27:25];
      a    = make_addr(22'h100 + 22'(seed[31:30]), 5'd8 + 5'(seed[29:28]), w);
      add_access(5, seed[24], a, lcg_next(seed), 2'd2, 1'b0, 32'h0);
      seed = lcg_next(seed);
    end
  endtask

  task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL time=%0t %s got=%0h exp=%0h", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input int t);
    $display("test %0d %s: %0d checks, %0d errors", t, test_name(t), test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  // hold the request until an edge where the stall is low
  task automatic run_entry(input entry_s e);
    int wb_before;
    bit stalled;
    wb_before  = mem0.wb_addr_q.size();
    stalled    = 1'b0;
    p1_addr    = e.addr;
    p1_data_wr = e.wr ? e.data : 32'h0;
    p1_read    = !e.wr;
    p1_write   = e.wr;
    @(negedge clk_i);
    while (p1_stall) begin
      stalled = 1'b1;
      @(negedge clk_i);
    end
    if (!e.wr) begin
      check("p1_data_o", 256'(p1_data_rd), 256'(e.data));
    end
    if (e.stall != 2'd2) begin
      check("p1_stall_o", 256'(stalled), 256'(e.stall[0]));
    end
    @(posedge clk_i);
    #1;
    if (e.wb) begin
      check("writeback count", 256'(mem0.wb_addr_q.size() - wb_before), 256'(1));
      check("mem_addr_o", 256'(mem0.wb_addr_q[$]), 256'(e.victim));
      check("mem_data_o", mem0.wb_line_q[$], e.victim_line);
    end
  endtask

  initial begin
    longint wd_ns;
    wait (table_done);
    wd_ns = longint'(table_q.size() + 20) * (2 * LATENCY + 8) * 100;
    #(wd_ns);
    $display("timeout: the cache did not finish the accesses in time");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int cur_test;
    clk_i      = 1'b0;
    rst_i      = 1'b0;
    p1_addr    = 32'h0;
    p1_data_wr = 32'h0;
    p1_read    = 1'b0;
    p1_write   = 1'b0;
    seed       = 32'h521d2530;
    build_table();
    table_done = 1'b1;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b1;

    // quiet bus with no request
    @(negedge clk_i);
    check("mem_enable_o", 256'(mem_enable), 256'(0));
    check("mem_write_o", 256'(mem_write), 256'(0));
    check("p1_stall_o", 256'(p1_stall), 256'(0));
    end_test(1);
    @(posedge clk_i);
    #1;

    cur_test = 2;
    foreach (table_q[i]) begin
      if (int'(table_q[i].test) != cur_test) begin
        end_test(cur_test);
        cur_test = int'(table_q[i].test);
      end
      run_entry(table_q[i]);
    end
    end_test(cur_test);
    p1_read  = 1'b0;
    p1_write = 1'b0;

    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+hw
hw/dcache_addr_pkg.sv
hw/dcache_ctrl_pkg.sv
hw/dcache_tag_sram.sv
hw/dcache_data_sram.sv
hw/dcache_controller.sv
hw/dcache_top.sv
tb/data_memory_model.sv
tb/dcache_sva.sv
tb/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module dcache_tb -Mdir obj_dir

status=0
out=$(./obj_dir/Vdcache_tb 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
  exit 0
fi
exit 1
